//--- common/arc_defs.svh
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Screen geometry of the small display
// Pixel clock enable divisors
// Tile map size and pixel latency
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ARC_DEFS_SVH
`define ARC_DEFS_SVH

// Horizontal, in pixels
`define ARC_HTOTAL      64
`define ARC_HACTIVE     48
`define ARC_HS_START    52
`define ARC_HS_LEN      4

// Vertical, in lines
`define ARC_VTOTAL      40
`define ARC_VACTIVE     32
`define ARC_VS_START    34
`define ARC_VS_LEN      2

// clk cycles per enable pulse
`define ARC_CEN2_DIV    2
`define ARC_CEN_DIV     4

// Tile map, 8x4 entries with 6 columns on screen
`define ARC_MAP_COLS    8
`define ARC_MAP_ROWS    4
`define ARC_TILE_COLS   6

// One tile of fetch plus two pixel stages
`define ARC_PIX_LAG     10

`endif

//--- common/arc_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the arcade core
// Video position and sync bundles
// CPU bus and tile ROM request
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package arc_pkg;

    // Plain widths
    typedef logic [8:0]  hcnt_t;
    typedef logic [8:0]  vcnt_t;
    typedef logic [7:0]  tile_code_t;
    typedef logic [1:0]  tile_color_t;
    typedef logic [3:0]  pix_t;
    // Colour bank on top of the pixel nibble
    typedef logic [5:0]  pal_idx_t;
    // Tile code on top of the pixel row
    typedef logic [10:0] rom_addr_t;
    // Leftmost pixel sits in the lowest nibble
    typedef logic [31:0] rom_data_t;
    typedef logic [15:0] cpu_word_t;
    // Top bit picks the palette, otherwise the tile map
    typedef logic [8:0]  cpu_addr_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

    typedef struct packed {
        hcnt_t hcount;
        vcnt_t vcount;
    } vid_pos_t;

    typedef struct packed {
        logic hs;
        logic vs;
        logic lhbl;
        logic lvbl;
    } vid_sync_t;

    typedef struct packed {
        logic       wr;
        logic       rd;
        cpu_addr_t  addr;
        cpu_word_t  data;
        logic [1:0] dsn;
    } cpu_bus_t;

    typedef struct packed {
        logic      cs;
        rom_addr_t addr;
    } rom_req_t;

endpackage

`default_nettype wire

//--- video/vid_timing.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Video timing generator
// Pixel clock enables, H/V counters
// Delayed sync and blanking, frame count
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "arc_defs.svh"

module vid_timing (
    input  wire                clk,
    input  wire                rst,
    output logic               pxl2_cen,
    output logic               pxl_cen,
    output arc_pkg::vid_pos_t  pos,
    output arc_pkg::vid_sync_t sync,
    output logic [7:0]         frame_cnt
);
    import arc_pkg::*;

    localparam logic [1:0] CEN_LAST  = 2'(`ARC_CEN_DIV - 1);
    localparam logic [1:0] CEN2_MASK = 2'(`ARC_CEN2_DIV - 1);
    localparam hcnt_t H_LAST = hcnt_t'(`ARC_HTOTAL - 1);
    localparam hcnt_t H_ACT  = hcnt_t'(`ARC_HACTIVE);
    localparam hcnt_t H_HS0  = hcnt_t'(`ARC_HS_START);
    localparam hcnt_t H_HS1  = hcnt_t'(`ARC_HS_START + `ARC_HS_LEN);
    localparam hcnt_t H_LAG  = hcnt_t'(`ARC_PIX_LAG - 1);
    localparam hcnt_t H_WRAP = hcnt_t'(`ARC_HTOTAL - `ARC_PIX_LAG + 1);
    localparam vcnt_t V_LAST = vcnt_t'(`ARC_VTOTAL - 1);
    localparam vcnt_t V_ACT  = vcnt_t'(`ARC_VACTIVE);
    localparam vcnt_t V_VS0  = vcnt_t'(`ARC_VS_START);
    localparam vcnt_t V_VS1  = vcnt_t'(`ARC_VS_START + `ARC_VS_LEN);

    logic [1:0] cen_cnt;
    hcnt_t      hpix;
    logic       lhbl_raw;
    logic       hs_raw;
    logic       lvbl_raw;
    logic       vs_raw;

    always_ff @(posedge clk) begin
        if (rst) begin
            cen_cnt  <= '0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cen_cnt  <= cen_cnt + 2'd1;
            pxl2_cen <= (cen_cnt & CEN2_MASK) == CEN2_MASK;
            pxl_cen  <= cen_cnt == CEN_LAST;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pos       <= '0;
            frame_cnt <= '0;
        end else if (pxl_cen) begin
            if (pos.hcount == H_LAST) begin
                pos.hcount <= '0;
                if (pos.vcount == V_LAST) begin
                    pos.vcount <= '0;
                    frame_cnt  <= frame_cnt + 8'd1;
                end else begin
                    pos.vcount <= pos.vcount + 1'b1;
                end
            end else begin
                pos.hcount <= pos.hcount + 1'b1;
            end
        end
    end

    // Screen column of the pixel that reaches rgb next period
    always_comb begin
        if (pos.hcount >= H_LAG) begin
            hpix = pos.hcount - H_LAG;
        end else begin
            hpix = pos.hcount + H_WRAP;
        end
        lhbl_raw = hpix < H_ACT;
        hs_raw   = hpix >= H_HS0 && hpix < H_HS1;
        lvbl_raw = pos.vcount < V_ACT;
        vs_raw   = pos.vcount >= V_VS0 && pos.vcount < V_VS1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sync <= '0;
        end else if (pxl_cen) begin
            sync.hs   <= hs_raw;
            sync.vs   <= vs_raw;
            sync.lhbl <= lhbl_raw;
            sync.lvbl <= lvbl_raw;
        end
    end

endmodule

`default_nettype wire

//--- video/char_layer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Character tile layer
// Tile map RAM with CPU port
// Per-tile ROM fetch with deadline
// Pixel shifter and late-fetch counter
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "arc_defs.svh"

module char_layer (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 pxl_cen,
    input  wire arc_pkg::vid_pos_t  pos,
    input  wire                 map_we,
    input  wire [4:0]           map_addr,
    input  wire arc_pkg::cpu_word_t cpu_data,
    input  wire [1:0]           dsn,
    output arc_pkg::cpu_word_t  map_dout,
    output arc_pkg::rom_req_t   rom_req,
    input  wire arc_pkg::rom_data_t rom_data,
    input  wire                 rom_ok,
    output arc_pkg::pal_idx_t   pix_idx,
    output logic [7:0]          late_cnt
);
    import arc_pkg::*;

    localparam int    MAP_SIZE  = `ARC_MAP_ROWS * `ARC_MAP_COLS;
    localparam hcnt_t FETCH_END = hcnt_t'(`ARC_TILE_COLS * 8);
    localparam vcnt_t V_ACT     = vcnt_t'(`ARC_VACTIVE);

    cpu_word_t   map_mem [MAP_SIZE];
    cpu_word_t   map_entry;
    tile_code_t  tile_code;
    logic        boundary;
    logic        fetch_en;
    logic        late_now;
    logic        busy;
    logic        restart;
    rom_data_t   word_q;
    rom_data_t   next_word;
    rom_data_t   shift_q;
    tile_color_t color_pend;
    tile_color_t color_q;
    pix_t        pixel;

    // CPU side, byte lanes written on low dsn
    always_ff @(posedge clk) begin
        if (map_we) begin
            if (!dsn[0]) begin
                map_mem[map_addr][7:0] <= cpu_data[7:0];
            end
            if (!dsn[1]) begin
                map_mem[map_addr][15:8] <= cpu_data[15:8];
            end
        end
        map_dout <= map_mem[map_addr];
    end

    // Video side, row from vcount/8 and column from hcount/8
    assign map_entry = map_mem[{pos.vcount[4:3], pos.hcount[5:3]}];
    assign tile_code = map_entry[7:0];

    assign boundary  = pxl_cen && pos.hcount[2:0] == 3'd0;
    assign fetch_en  = pos.vcount < V_ACT && pos.hcount < FETCH_END;
    // Request still open at the tile boundary
    assign late_now  = rom_req.cs && !rom_ok;
    assign next_word = (rom_req.cs && rom_ok) ? rom_data : word_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rom_req  <= '0;
            busy     <= 1'b0;
            restart  <= 1'b0;
            late_cnt <= '0;
        end else begin
            if (rom_req.cs && rom_ok) begin
                rom_req.cs <= 1'b0;
            end
            if (restart) begin
                rom_req.cs <= 1'b1;
                restart    <= 1'b0;
            end
            if (boundary) begin
                busy <= fetch_en;
                if (late_now) begin
                    // Abandon the fetch
                    rom_req.cs <= 1'b0;
                    if (late_cnt != 8'hff) begin
                        late_cnt <= late_cnt + 8'd1;
                    end
                end
                if (fetch_en) begin
                    rom_req.addr <= {tile_code, pos.vcount[2:0]};
                    // One idle clock after an abandoned request
                    if (late_now) begin
                        restart <= 1'b1;
                    end else begin
                        rom_req.cs <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rom_req.cs && rom_ok) begin
            word_q <= rom_data;
        end
        if (boundary && fetch_en) begin
            color_pend <= map_entry[9:8];
        end
        if (boundary) begin
            color_q <= busy ? color_pend : '0;
            shift_q <= (busy && !late_now) ? next_word : '0;
        end else if (pxl_cen) begin
            shift_q <= shift_q >> 4;
        end
    end

    assign pixel   = shift_q[3:0];
    assign pix_idx = {color_q, pixel};

endmodule

`default_nettype wire

//--- video/colmix.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Colour mixer
// Palette RAM with CPU port
// RGB555 lookup and blanking
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module colmix (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     pxl_cen,
    input  wire arc_pkg::pal_idx_t  pix_idx,
    input  wire arc_pkg::vid_sync_t sync,
    input  wire                     pal_we,
    input  wire arc_pkg::pal_idx_t  pal_addr,
    input  wire arc_pkg::cpu_word_t cpu_data,
    input  wire [1:0]               dsn,
    output arc_pkg::cpu_word_t      pal_dout,
    output arc_pkg::rgb_t           rgb
);
    import arc_pkg::*;

    cpu_word_t pal_mem [2**$bits(pal_idx_t)];
    cpu_word_t pal_word;
    rgb_t      rgb_q;

    always_ff @(posedge clk) begin
        if (pal_we) begin
            if (!dsn[0]) begin
                pal_mem[pal_addr][7:0] <= cpu_data[7:0];
            end
            if (!dsn[1]) begin
                pal_mem[pal_addr][15:8] <= cpu_data[15:8];
            end
        end
        pal_dout <= pal_mem[pal_addr];
    end

    assign pal_word = pal_mem[pix_idx];

    // Word layout is blue, green, red from the top
    always_ff @(posedge clk) begin
        if (rst) begin
            rgb_q <= '0;
        end else if (pxl_cen) begin
            rgb_q.red   <= pal_word[4:0];
            rgb_q.green <= pal_word[9:5];
            rgb_q.blue  <= pal_word[14:10];
        end
    end

    // Blanking edges move on the same pxl_cen as rgb_q
    assign rgb = (sync.lhbl && sync.lvbl) ? rgb_q : '0;

endmodule

`default_nettype wire

//--- hdl/arc_game.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Game top level
// Timing, tile layer and colour mixer
// CPU write decode and readback
// Status dump register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module arc_game (
    input  wire                     clk,
    input  wire                     rst,
    output logic                    pxl2_cen,
    output logic                    pxl_cen,
    output arc_pkg::rgb_t           rgb,
    output logic                    HS,
    output logic                    VS,
    output logic                    LHBL,
    output logic                    LVBL,
    input  wire arc_pkg::cpu_bus_t  cpu,
    output arc_pkg::cpu_word_t      cpu_din,
    input  wire [7:0]               st_addr,
    output logic [7:0]              st_dout,
    output arc_pkg::rom_req_t       rom_req,
    input  wire arc_pkg::rom_data_t rom_data,
    input  wire                     rom_ok
);
    import arc_pkg::*;

    vid_pos_t   pos;
    vid_sync_t  sync;
    pal_idx_t   pix_idx;
    logic [7:0] frame_cnt;
    logic [7:0] late_cnt;
    cpu_word_t  map_dout;
    cpu_word_t  pal_dout;
    cpu_word_t  rd_word;
    cpu_word_t  din_q;
    logic       map_we;
    logic       pal_we;
    logic       rd_q;
    logic       sel_pal;

    // Address bit 8 picks palette over tile map
    assign map_we = cpu.wr && !cpu.addr[8];
    assign pal_we = cpu.wr && cpu.addr[8];

    assign HS   = sync.hs;
    assign VS   = sync.vs;
    assign LHBL = sync.lhbl;
    assign LVBL = sync.lvbl;

    vid_timing u_timing (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .pxl2_cen  ( pxl2_cen  ),
        .pxl_cen   ( pxl_cen   ),
        .pos       ( pos       ),
        .sync      ( sync      ),
        .frame_cnt ( frame_cnt )
    );

    char_layer u_char (
        .clk       ( clk            ),
        .rst       ( rst            ),
        .pxl_cen   ( pxl_cen        ),
        .pos       ( pos            ),
        .map_we    ( map_we         ),
        .map_addr  ( cpu.addr[4:0]  ),
        .cpu_data  ( cpu.data       ),
        .dsn       ( cpu.dsn        ),
        .map_dout  ( map_dout       ),
        .rom_req   ( rom_req        ),
        .rom_data  ( rom_data       ),
        .rom_ok    ( rom_ok         ),
        .pix_idx   ( pix_idx        ),
        .late_cnt  ( late_cnt       )
    );

    colmix u_colmix (
        .clk       ( clk            ),
        .rst       ( rst            ),
        .pxl_cen   ( pxl_cen        ),
        .pix_idx   ( pix_idx        ),
        .sync      ( sync           ),
        .pal_we    ( pal_we         ),
        .pal_addr  ( cpu.addr[5:0]  ),
        .cpu_data  ( cpu.data       ),
        .dsn       ( cpu.dsn        ),
        .pal_dout  ( pal_dout       ),
        .rgb       ( rgb            )
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_q    <= 1'b0;
            sel_pal <= 1'b0;
            st_dout <= '0;
        end else begin
            rd_q <= cpu.rd;
            if (cpu.rd) begin
                sel_pal <= cpu.addr[8];
            end
            case (st_addr[7:4])
                4'd0:    st_dout <= frame_cnt;
                4'd1:    st_dout <= late_cnt;
                default: st_dout <= '0;
            endcase
        end
    end

    // RAM read data is live the cycle after rd, then held here
    assign rd_word = sel_pal ? pal_dout : map_dout;

    always_ff @(posedge clk) begin
        if (rd_q) begin
            din_q <= rd_word;
        end
    end

    assign cpu_din = rd_q ? rd_word : din_q;

endmodule

`default_nettype wire

//--- tb/sdram_model.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tile ROM slot responder
// Programmable latency on cs/addr/ok
// Contents computed from the address
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module sdram_model (
    input  wire                    clk,
    input  wire                    rst,
    input  wire arc_pkg::rom_req_t rom_req,
    input  wire [7:0]              latency,
    output arc_pkg::rom_data_t     rom_data,
    output logic                   rom_ok
);
    import arc_pkg::*;

    logic       cs_q;
    rom_addr_t  addr_q;
    logic [7:0] cnt;
    logic [7:0] age;
    logic       fresh;

    // Count starts over on a new address or after cs drops
    always_comb begin
        fresh  = !cs_q || (rom_req.addr != addr_q);
        age    = fresh ? 8'd0 : cnt;
        rom_ok = rom_req.cs && (age >= latency);
        for (int i = 0; i < 8; i++) begin
            // Nibble i is code + row + i, mod 16
            rom_data[4*i +: 4] = 4'(int'(rom_req.addr[10:3]) + int'(rom_req.addr[2:0]) + i);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q   <= 1'b0;
            addr_q <= '0;
            cnt    <= '0;
        end else begin
            cs_q   <= rom_req.cs;
            addr_q <= rom_req.addr;
            if (!rom_req.cs) begin
                cnt <= '0;
            end else if (age != 8'hff) begin
                cnt <= age + 8'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_arc_game.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the arcade core top
// Reset, CPU access, frame geometry
// Picture, frame counter, slow ROM
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none
`include "arc_defs.svh"

module tb_arc_game;
    import arc_pkg::*;

    localparam int         LINE_PIX    = `ARC_HTOTAL;
    localparam int         FRAME_LINES = `ARC_VTOTAL;
    localparam int         FRAME_PIX   = `ARC_HTOTAL * `ARC_VTOTAL;
    localparam logic [7:0] LATE_FRAME  = 8'(`ARC_TILE_COLS * `ARC_VACTIVE);
    localparam logic [1:0] SEL_LVBL    = 2'd0;
    localparam logic [1:0] SEL_LHBL    = 2'd1;
    localparam logic [1:0] SEL_VS      = 2'd2;

    logic       clk = 1'b0;
    logic       rst;
    cpu_bus_t   cpu;
    logic [7:0] st_addr;
    logic [7:0] latency;
    logic       pxl2_cen;
    logic       pxl_cen;
    rgb_t       rgb;
    logic       hs;
    logic       vs;
    logic       lhbl;
    logic       lvbl;
    cpu_word_t  cpu_din;
    logic [7:0] st_dout;
    rom_req_t   rom_req;
    rom_data_t  rom_data;
    logic       rom_ok;

    // Expected RAM contents
    cpu_word_t  map_exp [32];
    cpu_word_t  pal_exp [64];

    always #2 clk = ~clk;

    arc_game UUT (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .rgb      ( rgb      ),
        .HS       ( hs       ),
        .VS       ( vs       ),
        .LHBL     ( lhbl     ),
        .LVBL     ( lvbl     ),
        .cpu      ( cpu      ),
        .cpu_din  ( cpu_din  ),
        .st_addr  ( st_addr  ),
        .st_dout  ( st_dout  ),
        .rom_req  ( rom_req  ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   )
    );

    sdram_model u_rom (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .rom_req  ( rom_req  ),
        .latency  ( latency  ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   )
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic compare_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_word(input string name, input cpu_word_t got, input cpu_word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_status(input string name, input logic [7:0] got,
                                  input logic [7:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic compare_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic step_clock();
        @(posedge clk);
        #1;
    endtask

    // Advance to the next pixel period
    task automatic next_pixel();
        int waited;
        waited = 0;
        step_clock();
        while (pxl_cen !== 1'b1) begin
            waited++;
            if (waited > 8) begin
                abort_run("pxl_cen did not pulse within 8 clock cycles");
            end
            step_clock();
        end
    endtask

    function automatic logic sync_bit(input logic [1:0] sel);
        logic [3:0] now;
        now = {1'b0, vs, lhbl, lvbl};
        return now[sel];
    endfunction

    task automatic wait_level(input logic [1:0] sel, input logic level, input int limit,
                              input string what);
        int waited;
        waited = 0;
        while (sync_bit(sel) !== level) begin
            if (waited == limit) begin
                abort_run($sformatf("Timed out waiting for %s", what));
            end
            waited++;
            next_pixel();
        end
    endtask

    task automatic wait_rise(input logic [1:0] sel, input int limit, input string what);
        wait_level(sel, 1'b0, limit, what);
        wait_level(sel, 1'b1, limit, what);
    endtask

    task automatic read_status(input logic [7:0] page, output logic [7:0] value);
        st_addr = page;
        step_clock();
        value = st_dout;
    endtask

    function automatic cpu_word_t merge_bytes(input cpu_word_t old, input cpu_word_t data,
                                              input logic [1:0] dsn);
        cpu_word_t word;
        word = old;
        if (!dsn[0]) begin
            word[7:0] = data[7:0];
        end
        if (!dsn[1]) begin
            word[15:8] = data[15:8];
        end
        return word;
    endfunction

    function automatic pix_t rom_nibble(input tile_code_t code, input logic [2:0] row,
                                        input int pos);
        return pix_t'((int'(code) + int'(row) + pos) % 16);
    endfunction

    function automatic rgb_t pal_rgb(input cpu_word_t word);
        rgb_t c;
        c.red   = word[4:0];
        c.green = word[9:5];
        c.blue  = word[14:10];
        return c;
    endfunction

    task automatic cpu_write(input cpu_addr_t addr, input cpu_word_t data,
                             input logic [1:0] dsn);
        cpu.wr   = 1'b1;
        cpu.addr = addr;
        cpu.data = data;
        cpu.dsn  = dsn;
        step_clock();
        cpu.wr  = 1'b0;
        cpu.dsn = 2'b11;
        if (addr[8]) begin
            pal_exp[addr[5:0]] = merge_bytes(pal_exp[addr[5:0]], data, dsn);
        end else begin
            map_exp[addr[4:0]] = merge_bytes(map_exp[addr[4:0]], data, dsn);
        end
    endtask

    // Word appears one cycle after rd and stays a cycle later
    task automatic cpu_read_check(input cpu_addr_t addr);
        cpu_word_t exp;
        exp = addr[8] ? pal_exp[addr[5:0]] : map_exp[addr[4:0]];
        cpu.rd   = 1'b1;
        cpu.addr = addr;
        step_clock();
        compare_word($sformatf("cpu_din at 0x%h", addr), cpu_din, exp);
        cpu.rd   = 1'b0;
        cpu.addr = addr ^ 9'h101;
        step_clock();
        compare_word($sformatf("cpu_din held from 0x%h", addr), cpu_din, exp);
    endtask

    task automatic reset_state_test();
        logic [7:0] value;
        rst = 1'b1;
        repeat (5) step_clock();
        compare_flag("HS", hs, 1'b0);
        compare_flag("VS", vs, 1'b0);
        compare_flag("LHBL", lhbl, 1'b0);
        compare_flag("LVBL", lvbl, 1'b0);
        compare_flag("rom_req.cs", rom_req.cs, 1'b0);
        compare_rgb("rgb", rgb, '0);
        compare_status("st_dout", st_dout, 8'h00);
        rst = 1'b0;
        read_status(8'h00, value);
        compare_status("st_dout frame page", value, 8'h00);
        read_status(8'h10, value);
        compare_status("st_dout late page", value, 8'h00);
    endtask

    task automatic geometry_test();
        int   gap;
        int   half;
        int   total;
        int   act;
        int   pulse;
        logic was;
        next_pixel();
        for (int i = 0; i < 8; i++) begin
            gap  = 0;
            half = 0;
            do begin
                step_clock();
                gap++;
                if (pxl2_cen) begin
                    half++;
                end
            end while (pxl_cen !== 1'b1 && gap < 8);
            compare_count("clk per pxl_cen", gap, 4);
            compare_count("pxl2_cen per pxl_cen", half, 2);
        end
        // One line from LHBL rise to LHBL rise
        wait_rise(SEL_LHBL, LINE_PIX + 1, "LHBL to rise");
        total = 0;
        act   = 0;
        pulse = 0;
        do begin
            if (lhbl) begin
                act++;
            end
            if (hs) begin
                pulse++;
            end
            if (!(lhbl && lvbl)) begin
                compare_rgb("rgb in blanking", rgb, '0);
            end
            was = lhbl;
            next_pixel();
            total++;
        end while (!(lhbl && !was) && total <= 2 * LINE_PIX);
        compare_count("pixels per line", total, LINE_PIX);
        compare_count("LHBL pixels", act, `ARC_HACTIVE);
        compare_count("HS pixels", pulse, `ARC_HS_LEN);
        // One frame sampled at each LHBL rise
        wait_rise(SEL_LVBL, FRAME_PIX, "LVBL to rise");
        wait_rise(SEL_LHBL, LINE_PIX + 1, "LHBL to rise");
        total = 0;
        act   = 0;
        pulse = 0;
        do begin
            if (lvbl) begin
                act++;
            end else begin
                compare_rgb("rgb in vertical blanking", rgb, '0);
            end
            if (vs) begin
                pulse++;
            end
            was = lvbl;
            total++;
            wait_rise(SEL_LHBL, LINE_PIX + 1, "LHBL to rise");
        end while (!(lvbl && !was) && total <= 2 * FRAME_LINES);
        compare_count("lines per frame", total, FRAME_LINES);
        compare_count("LVBL lines", act, `ARC_VACTIVE);
        compare_count("VS lines", pulse, `ARC_VS_LEN);
    endtask

    task automatic cpu_access_test();
        cpu_addr_t  addr;
        logic [1:0] dsn;
        for (int i = 0; i < 32; i++) begin
            cpu_write({4'b0000, 5'(i)}, 16'($urandom), 2'b00);
        end
        for (int i = 0; i < 64; i++) begin
            cpu_write({3'b100, 6'(i)}, 16'($urandom), 2'b00);
        end
        // Byte enables pick both bytes or a single one
        for (int n = 0; n < 64; n++) begin
            addr = {1'($urandom_range(1, 0)), 8'($urandom)};
            dsn  = 2'($urandom_range(2, 0));
            cpu_write(addr, 16'($urandom), dsn);
            cpu_read_check(addr);
        end
        for (int i = 0; i < 32; i++) begin
            cpu_read_check({4'b0000, 5'(i)});
        end
        for (int i = 0; i < 64; i++) begin
            cpu_read_check({3'b100, 6'(i)});
        end
    endtask

    // Whole visible frame against palette and ROM contents
    task automatic check_frame(input logic slow);
        cpu_word_t entry;
        pix_t      nib;
        pal_idx_t  idx;
        wait_rise(SEL_LVBL, FRAME_PIX, "LVBL to rise");
        for (int row = 0; row < `ARC_VACTIVE; row++) begin
            wait_rise(SEL_LHBL, LINE_PIX + 1, "LHBL to rise");
            for (int col = 0; col < `ARC_HACTIVE; col++) begin
                entry = map_exp[5'((row / 8) * `ARC_MAP_COLS + col / 8)];
                nib   = slow ? 4'd0 : rom_nibble(entry[7:0], 3'(row % 8), col % 8);
                idx   = {entry[9:8], nib};
                compare_rgb($sformatf("rgb row %0d col %0d", row, col), rgb,
                            pal_rgb(pal_exp[idx]));
                next_pixel();
            end
        end
    endtask

    task automatic frame_count_test();
        logic [7:0] first;
        logic [7:0] value;
        wait_rise(SEL_VS, FRAME_PIX, "VS to rise");
        read_status(8'h00, first);
        for (int f = 1; f <= 3; f++) begin
            wait_rise(SEL_VS, FRAME_PIX, "VS to rise");
            read_status(8'h00, value);
            compare_status("frame counter", value, first + 8'(f));
            read_status(8'h10, value);
            compare_status("late counter", value, 8'h00);
            read_status(8'h2c, value);
            compare_status("unused status page", value, 8'h00);
        end
    endtask

    task automatic slow_rom_test();
        logic [7:0] value;
        // Latency changes while no fetch is in flight
        wait_level(SEL_LVBL, 1'b0, FRAME_PIX, "LVBL to fall");
        latency = 8'd40;
        check_frame(1'b1);
        wait_level(SEL_LVBL, 1'b0, FRAME_PIX, "LVBL to fall");
        read_status(8'h10, value);
        compare_status("late counter after one frame", value, LATE_FRAME);
        wait_rise(SEL_LVBL, FRAME_PIX, "LVBL to rise");
        wait_level(SEL_LVBL, 1'b0, FRAME_PIX, "LVBL to fall");
        read_status(8'h10, value);
        compare_status("late counter after two frames", value, 8'hff);
    endtask

    initial begin
        rst      = 1'b1;
        cpu      = '0;
        cpu.dsn  = 2'b11;
        st_addr  = 8'h00;
        latency  = 8'd3;
        void'($urandom(58));
        reset_state_test();
        cpu_access_test();
        geometry_test();
        check_frame(1'b0);
        frame_count_test();
        slow_rom_test();
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/arc_pkg.sv
video/vid_timing.sv
video/char_layer.sv
video/colmix.sv
hdl/arc_game.sv
tb/sdram_model.sv
tb/tb_arc_game.sv

//--- Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --timing -j 0
TOP      ?= tb_arc_game
FILELIST ?= tb.f
OBJDIR   ?= obj_dir
LOG      ?= sim.log
PASS_MSG := Testbench passed

BIN     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
